// File: Makefile
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = dcache_tb
FILELIST  = sources.f
OBJDIR    = obj_dir

.PHONY: all lint clean

all: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// File: rtl/dcache_bus_pkg.sv
package dcache_bus_pkg;

	// cpu and memory address / data
	localparam int ADDR_W = 32; // byte address
	localparam int DATA_W = 32; // one word per beat

	// byte enables of a cpu write
	localparam int STRB_W = 4;

	// line bursts on both memory channels
	localparam int BURST_BEATS = 8; // one line
	localparam int BEAT_W      = 3; // beat counter width

	// every burst carries full words in order 0 .. BURST_BEATS-1
	// last is raised on the final beat only

	// valid holds with stable payload until ready
	// no ready waits on its own valid

endpackage

// File: rtl/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl
	import dcache_geom_pkg::*;
	import dcache_bus_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  cpu_req_valid,
	input  logic                  cpu_req_write,  // 1 write, 0 read
	input  logic [ADDR_W-1:0]     cpu_req_addr,
	input  logic [DATA_W-1:0]     cpu_req_wdata,
	input  logic [STRB_W-1:0]     cpu_req_wstrb,
	output logic                  cpu_req_ready,
	output logic                  cpu_rsp_valid,
	output logic [DATA_W-1:0]     cpu_rsp_data,
	input  logic                  cpu_rsp_ready,
	output logic                  mem_rd_req_valid,
	output logic [ADDR_W-1:0]     mem_rd_req_addr,
	input  logic                  mem_rd_req_ready,
	input  logic                  mem_rd_rsp_valid,
	input  logic                  mem_rd_rsp_last,
	output logic                  mem_rd_rsp_ready,
	output logic                  mem_wr_req_valid,
	output logic [ADDR_W-1:0]     mem_wr_req_addr,
	input  logic                  mem_wr_req_ready,
	output logic                  mem_wr_data_valid,
	input  logic                  mem_wr_data_ready,
	output logic [INDEX_W-1:0]    index,
	output logic [TAG_W-1:0]      req_tag,
	output logic [WORD_SEL_W-1:0] word_sel,
	output logic [DATA_W-1:0]     wdata,
	output logic [STRB_W-1:0]     wstrb,
	output logic [NUM_WAYS-1:0]   tag_wen,
	output logic [NUM_WAYS-1:0]   data_wen,
	output logic [NUM_WAYS-1:0]   set_valid,
	output logic [NUM_WAYS-1:0]   clr_valid,
	output logic [NUM_WAYS-1:0]   set_dirty,
	output logic [NUM_WAYS-1:0]   clr_dirty,
	output logic [WAY_W-1:0]      victim_way,
	output logic [LINE_W-1:0]     wline,
	input  logic                  hit_any,
	input  logic [WAY_W-1:0]      hit_way,
	input  logic [DATA_W-1:0]     rd_word,
	input  logic [LINE_W-1:0]     merged_line,
	input  logic [TAG_W-1:0]      victim_tag,
	input  logic                  victim_dirty,
	input  logic [LINE_W-1:0]     refill_line,
	input  logic                  wb_last,
	output logic                  recv,
	output logic                  wb
);

	typedef enum logic [3:0] {
		ST_IDLE, ST_LOOKUP, ST_CACHE_WR, ST_RESP, ST_EVICT,
		ST_WB_REQ, ST_WB_DATA, ST_RD_REQ, ST_RECV, ST_REFILL
	} state_t;

	state_t state, state_nxt;

	logic [ADDR_W-1:0] addr_reg;  // accepted request
	logic [DATA_W-1:0] wdata_reg;
	logic [STRB_W-1:0] wstrb_reg;
	logic              write_reg;
	logic [WAY_W-1:0]  victim_ctr; // round-robin pointer
	logic [NUM_WAYS-1:0] hit_oh, victim_oh;

	always_ff @(posedge clk) begin
		if (rst)
			state <= ST_IDLE;
		else
			state <= state_nxt;
	end

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE:     if (cpu_req_valid) state_nxt = ST_LOOKUP;
			ST_LOOKUP: begin
				if (!hit_any)
					state_nxt = ST_EVICT;
				else
					state_nxt = write_reg ? ST_CACHE_WR : ST_RESP;
			end
			ST_CACHE_WR: state_nxt = ST_IDLE;
			ST_RESP:     if (cpu_rsp_ready) state_nxt = ST_IDLE;
			ST_EVICT:    state_nxt = victim_dirty ? ST_WB_REQ : ST_RD_REQ; // clean victim skips wb
			ST_WB_REQ:   if (mem_wr_req_ready) state_nxt = ST_WB_DATA;
			ST_WB_DATA:  if (mem_wr_data_ready && wb_last) state_nxt = ST_RD_REQ;
			ST_RD_REQ:   if (mem_rd_req_ready) state_nxt = ST_RECV;
			ST_RECV:     if (mem_rd_rsp_valid && mem_rd_rsp_last) state_nxt = ST_REFILL;
			ST_REFILL:   state_nxt = write_reg ? ST_CACHE_WR : ST_RESP; // now hits the new line
			default:     state_nxt = ST_IDLE;
		endcase
	end

	// request capture on the accepting edge
	always_ff @(posedge clk) begin
		if (cpu_req_valid && cpu_req_ready) begin
			addr_reg  <= cpu_req_addr;
			wdata_reg <= cpu_req_wdata;
			wstrb_reg <= cpu_req_wstrb;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			write_reg <= 1'b0;
		else if (cpu_req_valid && cpu_req_ready)
			write_reg <= cpu_req_write;
	end

	// advance on every miss, victim is the new value
	always_ff @(posedge clk) begin
		if (rst)
			victim_ctr <= '0;
		else if (state == ST_LOOKUP && !hit_any)
			victim_ctr <= victim_ctr + 1'b1;
	end

	// address fields of the held request
	assign index    = addr_reg[OFFSET_W +: INDEX_W];
	assign req_tag  = addr_reg[ADDR_W-1 -: TAG_W];
	assign word_sel = addr_reg[OFFSET_W-1 -: WORD_SEL_W];
	assign wdata    = wdata_reg;
	assign wstrb    = wstrb_reg;

	assign victim_way = victim_ctr;
	assign hit_oh     = NUM_WAYS'(1) << hit_way;
	assign victim_oh  = NUM_WAYS'(1) << victim_ctr;

	// way array controls
	assign tag_wen   = (state == ST_REFILL) ? victim_oh : '0;
	assign data_wen  = (state == ST_REFILL)   ? victim_oh :
	                   (state == ST_CACHE_WR) ? hit_oh : '0;
	assign set_valid = (state == ST_REFILL) ? victim_oh : '0;
	assign clr_valid = (state == ST_EVICT) ? victim_oh : '0;
	assign set_dirty = (state == ST_CACHE_WR) ? hit_oh : '0;
	assign clr_dirty = (state == ST_REFILL) ? victim_oh : '0;
	assign wline     = (state == ST_REFILL) ? refill_line : merged_line;

	// cpu handshake
	assign cpu_req_ready = (state == ST_IDLE);
	assign cpu_rsp_valid = (state == ST_RESP);
	assign cpu_rsp_data  = rd_word; // steady while in respond

	// memory bursts, line aligned addresses
	assign mem_wr_req_valid  = (state == ST_WB_REQ);
	assign mem_wr_req_addr   = {victim_tag, index, {OFFSET_W{1'b0}}};
	assign mem_wr_data_valid = (state == ST_WB_DATA);
	assign mem_rd_req_valid  = (state == ST_RD_REQ);
	assign mem_rd_req_addr   = {req_tag, index, {OFFSET_W{1'b0}}};
	assign mem_rd_rsp_ready  = (state == ST_RECV);

	assign recv = (state == ST_RECV);
	assign wb   = (state == ST_WB_DATA);

endmodule

// File: rtl/dcache_geom_pkg.sv
package dcache_geom_pkg;

	// organisation
	localparam int NUM_SETS = 8;
	localparam int NUM_WAYS = 4;

	// set index and way number
	localparam int INDEX_W = 3;   // log2 of NUM_SETS
	localparam int WAY_W   = 2;   // log2 of NUM_WAYS

	// byte address split is tag | index | offset
	localparam int OFFSET_W = 5;  // 32 byte lines
	localparam int TAG_W    = 24; // 32 - INDEX_W - OFFSET_W

	// one full line as the data array stores it
	localparam int LINE_W = 256;

	// word view of a line
	localparam int WORDS_PER_LINE = 8;
	localparam int WORD_SEL_W     = 3; // word number inside the line

	// the low offset bits below WORD_SEL_W pick a byte within the word
	// and are ignored by the cache, requests are word aligned

	// line address of a set is {tag, index, OFFSET_W zeros}
	// victim and refill share this form

endpackage

// File: rtl/dcache_line_buf.sv
`timescale 1ns/1ps

module dcache_line_buf
	import dcache_geom_pkg::*;
	import dcache_bus_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              recv,          // controller is taking refill beats
	input  logic              wb,            // controller is sending write-back beats
	input  logic              rd_rsp_valid,
	input  logic [DATA_W-1:0] rd_rsp_data,
	input  logic              wr_data_ready,
	input  logic [LINE_W-1:0] victim_line,
	output logic [LINE_W-1:0] refill_line,
	output logic [DATA_W-1:0] wb_word,
	output logic              wb_last
);

	logic [BEAT_W-1:0] beat_cnt;
	logic              rx_beat; // refill beat moves this cycle
	logic              tx_beat; // write-back beat moves this cycle
	logic              cnt_end;

	assign rx_beat = recv && rd_rsp_valid; // rsp ready equals recv
	assign tx_beat = wb && wr_data_ready;  // data valid equals wb
	assign cnt_end = (beat_cnt == BEAT_W'(BURST_BEATS - 1));

	// beat counter shared by both bursts
	always_ff @(posedge clk) begin
		if (rst) begin
			beat_cnt <= '0;
		end else if (rx_beat || tx_beat) begin
			if (cnt_end)
				beat_cnt <= '0; // back to zero for the next burst
			else
				beat_cnt <= beat_cnt + 1'b1;
		end
	end

	// refill assembly, one word per received beat
	always_ff @(posedge clk) begin
		if (rx_beat)
			refill_line[beat_cnt*DATA_W +: DATA_W] <= rd_rsp_data;
	end

	// write-back beat word straight from the victim line
	// the victim stays untouched until refill so no copy is taken
	assign wb_word = victim_line[beat_cnt*DATA_W +: DATA_W];

	// last beat of the write-back burst
	assign wb_last = wb && cnt_end;

endmodule

// File: rtl/dcache_top.sv
`timescale 1ns/1ps

module dcache_top
	import dcache_geom_pkg::*;
	import dcache_bus_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              cpu_req_valid,
	input  logic              cpu_req_write,
	input  logic [ADDR_W-1:0] cpu_req_addr,
	input  logic [DATA_W-1:0] cpu_req_wdata,
	input  logic [STRB_W-1:0] cpu_req_wstrb,
	output logic              cpu_req_ready,
	output logic              cpu_rsp_valid,
	output logic [DATA_W-1:0] cpu_rsp_data,
	input  logic              cpu_rsp_ready,
	output logic              mem_rd_req_valid,
	output logic [ADDR_W-1:0] mem_rd_req_addr,
	input  logic              mem_rd_req_ready,
	input  logic              mem_rd_rsp_valid,
	input  logic [DATA_W-1:0] mem_rd_rsp_data,
	input  logic              mem_rd_rsp_last,
	output logic              mem_rd_rsp_ready,
	output logic              mem_wr_req_valid,
	output logic [ADDR_W-1:0] mem_wr_req_addr,
	input  logic              mem_wr_req_ready,
	output logic              mem_wr_data_valid,
	output logic [DATA_W-1:0] mem_wr_data,
	output logic              mem_wr_data_last,
	input  logic              mem_wr_data_ready
);

	logic [INDEX_W-1:0]    index;
	logic [TAG_W-1:0]      req_tag;
	logic [WORD_SEL_W-1:0] word_sel;
	logic [DATA_W-1:0]     wdata;
	logic [STRB_W-1:0]     wstrb;
	logic [NUM_WAYS-1:0]   tag_wen, data_wen, set_valid, clr_valid, set_dirty, clr_dirty;
	logic [WAY_W-1:0]      victim_way, hit_way;
	logic [LINE_W-1:0]     wline, merged_line, victim_line, refill_line;
	logic [NUM_WAYS-1:0]   hits, dirties; // per way lookup results
	logic [TAG_W-1:0]      rtags  [NUM_WAYS];
	logic [LINE_W-1:0]     rlines [NUM_WAYS];
	logic                  hit_any, victim_dirty, recv, wb;
	logic [DATA_W-1:0]     rd_word;
	logic [TAG_W-1:0]      victim_tag;

	// four identical ways, same index and tag, own enables
	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
		dcache_way way_i (
			.clk, .rst, .index, .req_tag,
			.tag_wen(tag_wen[w]), .data_wen(data_wen[w]), .wline,
			.set_valid(set_valid[w]), .clr_valid(clr_valid[w]),
			.set_dirty(set_dirty[w]), .clr_dirty(clr_dirty[w]),
			.hit(hits[w]), .rtag(rtags[w]), .rline(rlines[w]), .dirty(dirties[w])
		);
	end

	dcache_way_sel way_sel_i (
		.hits, .rtags, .rlines, .dirties, .victim_way, .word_sel, .wdata, .wstrb,
		.hit_any, .hit_way, .rd_word, .merged_line, .victim_tag, .victim_line, .victim_dirty
	);

	// write-back data and last go straight out to memory
	dcache_line_buf line_buf_i (
		.clk, .rst, .recv, .wb,
		.rd_rsp_valid(mem_rd_rsp_valid), .rd_rsp_data(mem_rd_rsp_data),
		.wr_data_ready(mem_wr_data_ready), .victim_line, .refill_line,
		.wb_word(mem_wr_data), .wb_last(mem_wr_data_last)
	);

	dcache_ctrl ctrl_i (.*, .wb_last(mem_wr_data_last));

endmodule

// File: rtl/dcache_way.sv
`timescale 1ns/1ps

module dcache_way
	import dcache_geom_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic [INDEX_W-1:0] index,     // set being looked up / written
	input  logic [TAG_W-1:0]  req_tag,   // compared and also stored on tag_wen
	input  logic              tag_wen,
	input  logic              data_wen,
	input  logic [LINE_W-1:0] wline,     // line written on data_wen
	input  logic              set_valid,
	input  logic              clr_valid,
	input  logic              set_dirty,
	input  logic              clr_dirty,
	output logic              hit,
	output logic [TAG_W-1:0]  rtag,
	output logic [LINE_W-1:0] rline,
	output logic              dirty
);

	logic [TAG_W-1:0]    tag_arr  [NUM_SETS]; // tags
	logic [LINE_W-1:0]   data_arr [NUM_SETS]; // line storage
	logic [NUM_SETS-1:0] valid_bits;
	logic [NUM_SETS-1:0] dirty_bits;

	// tag array, written only at refill
	always_ff @(posedge clk) begin
		if (tag_wen)
			tag_arr[index] <= req_tag;
	end

	// data array, refill or write hit merge
	always_ff @(posedge clk) begin
		if (data_wen)
			data_arr[index] <= wline;
	end

	// valid bits
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_bits <= '0;
		end else if (set_valid) begin
			valid_bits[index] <= 1'b1; // line refilled
		end else if (clr_valid) begin
			valid_bits[index] <= 1'b0; // line picked for eviction
		end
	end

	// dirty bits
	always_ff @(posedge clk) begin
		if (rst) begin
			dirty_bits <= '0;
		end else if (set_dirty) begin
			dirty_bits[index] <= 1'b1; // write hit
		end else if (clr_dirty) begin
			dirty_bits[index] <= 1'b0; // fresh line from memory
		end
	end

	// combinational read of the indexed entry
	assign rtag  = tag_arr[index];
	assign rline = data_arr[index];
	assign dirty = dirty_bits[index];

	// tag compare
	assign hit = valid_bits[index] && (tag_arr[index] == req_tag);

endmodule

// File: rtl/dcache_way_sel.sv
`timescale 1ns/1ps

module dcache_way_sel
	import dcache_geom_pkg::*;
	import dcache_bus_pkg::*;
(
	input  logic [NUM_WAYS-1:0]   hits,
	input  logic [TAG_W-1:0]      rtags  [NUM_WAYS],
	input  logic [LINE_W-1:0]     rlines [NUM_WAYS],
	input  logic [NUM_WAYS-1:0]   dirties,
	input  logic [WAY_W-1:0]      victim_way,
	input  logic [WORD_SEL_W-1:0] word_sel,    // word inside the line
	input  logic [DATA_W-1:0]     wdata,
	input  logic [STRB_W-1:0]     wstrb,
	output logic                  hit_any,
	output logic [WAY_W-1:0]      hit_way,
	output logic [DATA_W-1:0]     rd_word,
	output logic [LINE_W-1:0]     merged_line, // hit line with the write applied
	output logic [TAG_W-1:0]      victim_tag,
	output logic [LINE_W-1:0]     victim_line,
	output logic                  victim_dirty
);

	logic [LINE_W-1:0] hit_line;
	logic [DATA_W-1:0] merged_word;

	// encode the hit vector, at most one way hits
	always_comb begin
		hit_way = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (hits[w])
				hit_way = WAY_W'(w);
		end
	end

	assign hit_any  = |hits;
	assign hit_line = rlines[hit_way];
	assign rd_word  = hit_line[word_sel*DATA_W +: DATA_W]; // addressed word

	// byte merge of the strobed write data
	always_comb begin
		for (int b = 0; b < STRB_W; b++) begin
			merged_word[b*8 +: 8] = wstrb[b] ? wdata[b*8 +: 8] : rd_word[b*8 +: 8];
		end
	end

	// put the merged word back at its slot, other words untouched
	always_comb begin
		for (int i = 0; i < WORDS_PER_LINE; i++) begin
			if (WORD_SEL_W'(i) == word_sel)
				merged_line[i*DATA_W +: DATA_W] = merged_word;
			else
				merged_line[i*DATA_W +: DATA_W] = hit_line[i*DATA_W +: DATA_W];
		end
	end

	// victim way mux for eviction and write-back
	assign victim_tag   = rtags[victim_way];
	assign victim_line  = rlines[victim_way];
	assign victim_dirty = dirties[victim_way];

endmodule

// File: sources.f
rtl/dcache_geom_pkg.sv
rtl/dcache_bus_pkg.sv
rtl/dcache_way.sv
rtl/dcache_way_sel.sv
rtl/dcache_line_buf.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
verification/clk_gen.sv
verification/dcache_tb.sv

// File: verification/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	// reset held over the first 5 rising edges
	initial begin
		rst = 1'b1;
		repeat (5) @(posedge clk);
		#1 rst = 1'b0;
	end

endmodule

// File: verification/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb
	import dcache_geom_pkg::*;
	import dcache_bus_pkg::*;
;

	typedef struct packed {
		logic              wr;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		logic [STRB_W-1:0] strb;
		logic [DATA_W-1:0] exp;     // expected read word
		logic              rd_miss; // refill burst expected
		logic              wb_miss; // write-back burst expected
	} vec_t;

	localparam int N_VEC = 11;
	localparam logic [DATA_W-1:0] FILL = 32'h5A5A_C3C3; // memory word = address ^ FILL

	// set 2 holds tags 0x10..0x14, set 3 takes the write miss
	vec_t vecs [N_VEC] = '{
		'{1'b0, 32'h0000_1048, 32'h0,         4'h0, 32'h5A5A_D38B, 1'b1, 1'b0},
		'{1'b0, 32'h0000_1048, 32'h0,         4'h0, 32'h5A5A_D38B, 1'b0, 1'b0},
		'{1'b1, 32'h0000_1048, 32'hDEAD_BEEF, 4'h5, 32'h0,         1'b0, 1'b0},
		'{1'b0, 32'h0000_1048, 32'h0,         4'h0, 32'h5AAD_D3EF, 1'b0, 1'b0},
		'{1'b1, 32'h0000_2064, 32'h1234_5678, 4'hC, 32'h0,         1'b1, 1'b0},
		'{1'b0, 32'h0000_2064, 32'h0,         4'h0, 32'h1234_E3A7, 1'b0, 1'b0},
		'{1'b0, 32'h0000_1148, 32'h0,         4'h0, 32'h5A5A_D28B, 1'b1, 1'b0},
		'{1'b0, 32'h0000_1248, 32'h0,         4'h0, 32'h5A5A_D18B, 1'b1, 1'b0},
		'{1'b0, 32'h0000_1348, 32'h0,         4'h0, 32'h5A5A_D08B, 1'b1, 1'b1},
		'{1'b0, 32'h0000_1448, 32'h0,         4'h0, 32'h5A5A_D78B, 1'b1, 1'b0},
		'{1'b0, 32'h0000_1048, 32'h0,         4'h0, 32'h5AAD_D3EF, 1'b1, 1'b0}
	};
	string names [N_VEC] = '{
		"read_miss", "read_hit", "write_hit", "read_merged", "write_miss", "read_alloc",
		"evict_fill_1", "evict_fill_2", "evict_dirty", "evict_fill_4", "reread_written_back"
	};

	logic              clk, rst;
	logic              cpu_req_valid, cpu_req_write, cpu_req_ready;
	logic [ADDR_W-1:0] cpu_req_addr;
	logic [DATA_W-1:0] cpu_req_wdata, cpu_rsp_data;
	logic [STRB_W-1:0] cpu_req_wstrb;
	logic              cpu_rsp_valid, cpu_rsp_ready;
	logic              mem_rd_req_valid, mem_rd_req_ready, mem_rd_rsp_valid;
	logic              mem_rd_rsp_last, mem_rd_rsp_ready;
	logic [ADDR_W-1:0] mem_rd_req_addr, mem_wr_req_addr;
	logic [DATA_W-1:0] mem_rd_rsp_data, mem_wr_data;
	logic              mem_wr_req_valid, mem_wr_req_ready;
	logic              mem_wr_data_valid, mem_wr_data_last, mem_wr_data_ready;

	logic [DATA_W-1:0] mem_arr [logic [ADDR_W-1:0]]; // only written-back words
	logic [ADDR_W-1:0] cur_addr;     // request in flight
	logic [ADDR_W-1:0] last_wb_addr;
	int                rd_bursts = 0;
	int                wb_bursts = 0;
	integer            seed = 70;

	clk_gen clk_gen_i (.clk, .rst);

	dcache_top dcache_top_i (.*);

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] exp,
	                               input logic [31:0] act);
		fail_now($sformatf("MISMATCH %s expected %08h actual %08h", name, exp, act));
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1; // drive and sample clear of the edge
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) next_cycle();
	endtask

	function automatic int rand_delay();
		return int'($unsigned($random(seed)) % 32'd4); // 0..3 cycles
	endfunction

	function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] a);
		if (mem_arr.exists(a))
			return mem_arr[a];
		return a ^ FILL; // untouched word, fill pattern
	endfunction

	// memory read channel, request then 8 response beats
	initial begin : rd_mem
		logic [ADDR_W-1:0] base;
		mem_rd_req_ready = 1'b0;
		mem_rd_rsp_valid = 1'b0;
		mem_rd_rsp_data  = '0;
		mem_rd_rsp_last  = 1'b0;
		forever begin
			next_cycle();
			if (mem_rd_req_valid) begin
				base = mem_rd_req_addr;
				rd_bursts++;
				assert (base == {cur_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}})
					else report_mismatch("refill_addr", cur_addr & ~32'h1F, base);
				idle_cycles(rand_delay());
				mem_rd_req_ready = 1'b1;
				next_cycle(); // request taken here
				mem_rd_req_ready = 1'b0;
				for (int b = 0; b < BURST_BEATS; b++) begin
					idle_cycles(rand_delay());
					mem_rd_rsp_valid = 1'b1;
					mem_rd_rsp_data  = mem_word(base + 32'(b * 4));
					mem_rd_rsp_last  = (b == BURST_BEATS - 1);
					while (!mem_rd_rsp_ready)
						next_cycle();
					next_cycle(); // beat taken
					mem_rd_rsp_valid = 1'b0;
					mem_rd_rsp_last  = 1'b0;
				end
			end
		end
	end

	// memory write channel, write-back beats update the array
	initial begin : wr_mem
		logic [ADDR_W-1:0] base;
		mem_wr_req_ready  = 1'b0;
		mem_wr_data_ready = 1'b0;
		forever begin
			next_cycle();
			if (mem_wr_req_valid) begin
				base         = mem_wr_req_addr;
				last_wb_addr = base;
				wb_bursts++;
				idle_cycles(rand_delay());
				mem_wr_req_ready = 1'b1;
				next_cycle();
				mem_wr_req_ready = 1'b0;
				for (int b = 0; b < BURST_BEATS; b++) begin
					idle_cycles(rand_delay());
					while (!mem_wr_data_valid)
						next_cycle();
					assert (mem_wr_data_last == (b == BURST_BEATS - 1))
						else fail_now("write-back last flag on the wrong beat");
					mem_arr[base + 32'(b * 4)] = mem_wr_data; // payload steady until ready
					mem_wr_data_ready = 1'b1;
					next_cycle();
					mem_wr_data_ready = 1'b0;
				end
			end
		end
	end

	// one table entry, request through response or ready return
	task automatic run_vec(input int i);
		vec_t v;
		int   rd0, wb0, lat, hold;
		logic [DATA_W-1:0] held;
		v   = vecs[i];
		rd0 = rd_bursts;
		wb0 = wb_bursts;
		while (!cpu_req_ready)
			next_cycle();
		cur_addr      = v.addr;
		cpu_req_valid = 1'b1;
		cpu_req_write = v.wr;
		cpu_req_addr  = v.addr;
		cpu_req_wdata = v.data;
		cpu_req_wstrb = v.strb;
		next_cycle(); // accepting edge
		cpu_req_valid = 1'b0;
		lat = 1;
		if (v.wr) begin
			while (!cpu_req_ready) begin
				next_cycle();
				lat++;
			end
		end else begin
			while (!cpu_rsp_valid) begin
				next_cycle();
				lat++;
			end
			held = cpu_rsp_data;
			hold = 1 + rand_delay(); // back-pressure on the response
			repeat (hold) begin
				next_cycle();
				assert (cpu_rsp_valid && cpu_rsp_data == held)
					else fail_now({names[i], ": response changed while held"});
			end
			cpu_rsp_ready = 1'b1;
			next_cycle();
			cpu_rsp_ready = 1'b0;
			assert (held == v.exp) else report_mismatch(names[i], v.exp, held);
		end
		assert ((rd_bursts - rd0) == int'(v.rd_miss))
			else report_mismatch({names[i], "_refills"}, 32'(v.rd_miss), rd_bursts - rd0);
		assert ((wb_bursts - wb0) == int'(v.wb_miss))
			else report_mismatch({names[i], "_writebacks"}, 32'(v.wb_miss), wb_bursts - wb0);
		if (!v.rd_miss) begin
			// hit timing counted in edges from acceptance
			assert (lat == (v.wr ? 3 : 2))
				else report_mismatch({names[i], "_latency"}, v.wr ? 3 : 2, lat);
		end
	endtask

	initial begin : main
		cpu_req_valid = 1'b0;
		cpu_req_write = 1'b0;
		cpu_req_addr  = '0;
		cpu_req_wdata = '0;
		cpu_req_wstrb = '0;
		cpu_rsp_ready = 1'b0;
		cur_addr      = '0;
		@(negedge rst);
		next_cycle();
		assert (cpu_req_ready && !cpu_rsp_valid && !mem_rd_req_valid && !mem_wr_req_valid)
			else fail_now("handshake outputs not idle after reset");
		for (int i = 0; i < N_VEC; i++)
			run_vec(i);
		// dirty line of tag 0x10 went out once, merged word included
		assert (wb_bursts == 1) else report_mismatch("writeback_count", 1, wb_bursts);
		assert (last_wb_addr == 32'h0000_1040)
			else report_mismatch("writeback_addr", 32'h0000_1040, last_wb_addr);
		assert (mem_word(32'h0000_1048) == 32'h5AAD_D3EF)
			else report_mismatch("writeback_word", 32'h5AAD_D3EF, mem_word(32'h0000_1048));
		$display("TEST PASSED");
		$finish;
	end

	// budget of 400 cycles per entry plus reset
	initial begin : watchdog
		repeat (N_VEC * 400 + 10) @(posedge clk);
		fail_now("timeout, the cache stopped answering");
	end

endmodule
